// File: src/watch_config.svh
`ifndef WATCH_CONFIG_SVH
`define WATCH_CONFIG_SVH

// Timekeeping
`define WATCH_TICK_DIV     1000     // CLK cycles per second

// LCD strobe timing
`define LCD_HALF_DIV       5        // CLK cycles per half LCD_E period

// Last step index of each sequencer state
`define LCD_DELAY_STEPS    70
`define LCD_CMD_STEPS      30
`define LCD_LINE_STEPS     20

// Controller commands
`define LCD_FUNC_SET       8'h3C    // 8-bit bus, 2 lines, 5x11 font
`define LCD_DISP_ON        8'h0C    // Display on, no cursor
`define LCD_ENTRY_MODE     8'h06    // Increment address, no shift

// DDRAM address commands
`define LCD_LINE1_ADDR     8'h80
`define LCD_LINE2_ADDR     8'hC0

// Character codes
`define LCD_SPACE          8'h20
`define LCD_COLON          8'h3A

`endif

// File: src/watch_pkg.sv
package watch_pkg;

   // Hour of day, 0 to 23
   typedef logic [4:0] hour_t;

   // Minute or second, 0 to 59
   typedef logic [5:0] min_sec_t;

   typedef enum logic [1:0] {
      FIELD_NONE = 2'd0,
      FIELD_SEC  = 2'd1,
      FIELD_MIN  = 2'd2,
      FIELD_HOUR = 2'd3
   } set_field_e;

   typedef enum logic {
      MODE_24H = 1'b0,
      MODE_12H = 1'b1
   } disp_mode_e;

endpackage

// File: src/lcd_pkg.sv
package lcd_pkg;

   // Controller sequence, run once from DELAY then LINE1/LINE2 forever
   typedef enum logic [2:0] {
      ST_DELAY      = 3'd0,
      ST_FUNC_SET   = 3'd1,
      ST_DISP_ON    = 3'd2,
      ST_ENTRY_MODE = 3'd3,
      ST_LINE1      = 3'd4,
      ST_LINE2      = 3'd5
   } lcd_state_e;

   // Character or command byte on LCD_DATA
   typedef logic [7:0] lcd_char_t;

   // Step index inside a state
   typedef logic [6:0] lcd_step_t;

   typedef enum logic {
      LINE_1 = 1'b0,
      LINE_2 = 1'b1
   } lcd_line_e;

endpackage

// File: src/disp_slot_if.sv
`timescale 1ns/1ns

interface disp_slot_if
   import lcd_pkg::*;
();

   lcd_line_e line;        // Line being written
   lcd_step_t step;        // Step n writes column n-1
   logic      text_phase;  // Steps 1 to 16 of a line state
   lcd_char_t char;        // Character for the current slot

   modport seq (
      output line,
      output step,
      output text_phase,
      input  char
   );

   modport fmt (
      input  line,
      input  step,
      input  text_phase,
      output char
   );

endinterface

// File: src/watch_input.sv
`timescale 1ns/1ns

module watch_input
   import watch_pkg::*;
(
   input  logic       CLK,
   input  logic       RESETN,
   input  logic       U,
   input  logic       D,
   input  set_field_e set_field,
   output logic       sec_up,
   output logic       sec_dn,
   output logic       min_up,
   output logic       min_dn,
   output logic       hour_up,
   output logic       hour_dn
);

   logic [1:0] btn_meta;   // Bit 0 is U, bit 1 is D
   logic [1:0] btn_sync;
   logic [1:0] btn_last;
   logic [1:0] btn_pulse;
   logic       up;
   logic       down;

   always_ff @(posedge CLK)
   begin
      if (!RESETN)
      begin
         btn_meta  <= '0;
         btn_sync  <= '0;
         btn_last  <= '0;
         btn_pulse <= '0;
      end
      else
      begin
         btn_meta  <= {D, U};
         btn_sync  <= btn_meta;
         btn_last  <= btn_sync;
         btn_pulse <= btn_sync & ~btn_last;   // Rising edge
      end
   end

   assign up   = btn_pulse[0];
   assign down = btn_pulse[1] & ~btn_pulse[0];   // U wins on a tie

   assign sec_up  = up   && (set_field == FIELD_SEC);
   assign sec_dn  = down && (set_field == FIELD_SEC);
   assign min_up  = up   && (set_field == FIELD_MIN);
   assign min_dn  = down && (set_field == FIELD_MIN);
   assign hour_up = up   && (set_field == FIELD_HOUR);
   assign hour_dn = down && (set_field == FIELD_HOUR);

endmodule

// File: src/watch_timekeeper.sv
`timescale 1ns/1ns

`include "watch_config.svh"

module watch_timekeeper
   import watch_pkg::*;
(
   input  logic     CLK,
   input  logic     RESETN,
   input  logic     sec_up,
   input  logic     sec_dn,
   input  logic     min_up,
   input  logic     min_dn,
   input  logic     hour_up,
   input  logic     hour_dn,
   output hour_t    hour,
   output min_sec_t minute,
   output min_sec_t second
);

   localparam int       PRESC_W     = $clog2(`WATCH_TICK_DIV);
   localparam min_sec_t MIN_SEC_MAX = 6'd59;
   localparam min_sec_t HOUR_MAX    = 6'd23;

   logic [PRESC_W-1:0] presc;
   logic               presc_wrap;
   logic               tick;
   logic               any_set;
   logic               tick_ok;
   logic               sec_carry;
   logic               min_carry;

   // One step up or down with wrap at both ends
   function automatic min_sec_t step_wrap(input min_sec_t value, input min_sec_t max,
                                          input logic up_dir);
      min_sec_t result;
      if (up_dir)
         result = (value == max) ? '0 : value + 6'd1;
      else
         result = (value == '0) ? max : value - 6'd1;
      return result;
   endfunction

   assign presc_wrap = (presc == PRESC_W'(`WATCH_TICK_DIV - 1));
   assign any_set    = sec_up | sec_dn | min_up | min_dn | hour_up | hour_dn;
   assign tick_ok    = tick & ~any_set;   // A set swallows the tick
   assign sec_carry  = tick_ok & (second == MIN_SEC_MAX);
   assign min_carry  = sec_carry & (minute == MIN_SEC_MAX);

   always_ff @(posedge CLK)
   begin
      if (!RESETN)
      begin
         presc  <= '0;
         tick   <= 1'b0;
         second <= '0;
         minute <= '0;
         hour   <= '0;
      end
      else
      begin
         presc <= presc_wrap ? '0 : presc + 1'b1;
         tick  <= presc_wrap;

         if (sec_up || sec_dn)
            second <= step_wrap(second, MIN_SEC_MAX, sec_up);
         else if (tick_ok)
            second <= step_wrap(second, MIN_SEC_MAX, 1'b1);

         if (min_up || min_dn)
            minute <= step_wrap(minute, MIN_SEC_MAX, min_up);
         else if (sec_carry)
            minute <= step_wrap(minute, MIN_SEC_MAX, 1'b1);

         if (hour_up || hour_dn)
            hour <= hour_t'(step_wrap(min_sec_t'(hour), HOUR_MAX, hour_up));
         else if (min_carry)
            hour <= hour_t'(step_wrap(min_sec_t'(hour), HOUR_MAX, 1'b1));
      end
   end

endmodule

// File: src/lcd_text_formatter.sv
`timescale 1ns/1ns

`include "watch_config.svh"

module lcd_text_formatter
   import watch_pkg::*;
   import lcd_pkg::*;
(
   input  hour_t      hour,
   input  min_sec_t   minute,
   input  min_sec_t   second,
   input  disp_mode_e mode,
   disp_slot_if.fmt   slot
);

   hour_t       disp_hour;
   logic [15:0] hour_chars;
   logic [15:0] min_chars;
   logic [15:0] sec_chars;
   logic        is_pm;

   // Tens and units as two ASCII digits
   function automatic logic [15:0] two_digits(input min_sec_t value);
      logic [3:0] tens;
      logic [3:0] units;
      tens  = 4'(value / 10);
      units = 4'(value % 10);
      return {4'h3, tens, 4'h3, units};
   endfunction

   assign is_pm = (hour >= 5'd12);

   always_comb
   begin
      disp_hour = hour;
      if (mode == MODE_12H)
      begin
         if (hour == 5'd0)
            disp_hour = 5'd12;   // Midnight reads 12 AM
         else if (hour > 5'd12)
            disp_hour = hour - 5'd12;
      end
   end

   assign hour_chars = two_digits(min_sec_t'(disp_hour));
   assign min_chars  = two_digits(minute);
   assign sec_chars  = two_digits(second);

   always_comb
   begin
      slot.char = `LCD_SPACE;
      if (slot.text_phase)
      begin
         if (slot.line == LINE_1)
         begin
            case (slot.step)
               7'd2:    slot.char = "L";
               7'd3:    slot.char = "C";
               7'd4:    slot.char = "D";
               7'd5:    slot.char = "_";
               7'd6:    slot.char = "W";
               7'd7:    slot.char = "A";
               7'd8:    slot.char = "T";
               7'd9:    slot.char = "C";
               7'd10:   slot.char = "H";
               7'd12:
               begin
                  if (mode == MODE_12H)
                     slot.char = is_pm ? "P" : "A";
               end
               7'd13:
               begin
                  if (mode == MODE_12H)
                     slot.char = "M";
               end
               default: slot.char = `LCD_SPACE;
            endcase
         end
         else
         begin
            case (slot.step)
               7'd4:    slot.char = hour_chars[15:8];
               7'd5:    slot.char = hour_chars[7:0];
               7'd6:    slot.char = `LCD_COLON;
               7'd7:    slot.char = min_chars[15:8];
               7'd8:    slot.char = min_chars[7:0];
               7'd10:   slot.char = sec_chars[15:8];
               7'd11:   slot.char = sec_chars[7:0];
               default: slot.char = `LCD_SPACE;   // Includes the gap at step 9
            endcase
         end
      end
   end

endmodule

// File: src/lcd_sequencer.sv
`timescale 1ns/1ns

`include "watch_config.svh"

module lcd_sequencer
   import lcd_pkg::*;
(
   input  logic      CLK,
   input  logic      RESETN,
   disp_slot_if.seq  slot,
   output logic      LCD_E,
   output logic      LCD_RS,
   output logic      LCD_RW,
   output lcd_char_t LCD_DATA
);

   localparam int HALF_W = $clog2(`LCD_HALF_DIV);

   logic [HALF_W-1:0] half_cnt;
   logic              half_wrap;
   logic              step_en;
   lcd_state_e        state;
   lcd_state_e        next_state;
   lcd_step_t         step;
   lcd_step_t         last_step;
   logic              rs_next;
   logic              rw_next;
   lcd_char_t         data_next;

   assign half_wrap = (half_cnt == HALF_W'(`LCD_HALF_DIV - 1));
   assign step_en   = half_wrap & LCD_E;   // E about to fall

   assign slot.line       = (state == ST_LINE2) ? LINE_2 : LINE_1;
   assign slot.step       = step;
   assign slot.text_phase = ((state == ST_LINE1) || (state == ST_LINE2)) &&
                            (step >= 7'd1) && (step <= 7'd16);

   always_comb
   begin
      case (state)
         ST_DELAY:           last_step = lcd_step_t'(`LCD_DELAY_STEPS);
         ST_LINE1, ST_LINE2: last_step = lcd_step_t'(`LCD_LINE_STEPS);
         default:            last_step = lcd_step_t'(`LCD_CMD_STEPS);
      endcase
      case (state)
         ST_DELAY:      next_state = ST_FUNC_SET;
         ST_FUNC_SET:   next_state = ST_DISP_ON;
         ST_DISP_ON:    next_state = ST_ENTRY_MODE;
         ST_ENTRY_MODE: next_state = ST_LINE1;
         ST_LINE1:      next_state = ST_LINE2;
         ST_LINE2:      next_state = ST_LINE1;
         default:       next_state = ST_DELAY;
      endcase
   end

   // Pin values for the current state and step
   always_comb
   begin
      rs_next   = 1'b0;
      rw_next   = 1'b0;
      data_next = '0;
      case (state)
         ST_FUNC_SET:   data_next = `LCD_FUNC_SET;
         ST_DISP_ON:    data_next = `LCD_DISP_ON;
         ST_ENTRY_MODE: data_next = `LCD_ENTRY_MODE;
         ST_LINE1, ST_LINE2:
         begin
            if (step == '0)
               data_next = (slot.line == LINE_2) ? `LCD_LINE2_ADDR : `LCD_LINE1_ADDR;
            else
            begin
               rs_next   = 1'b1;
               data_next = slot.text_phase ? slot.char : `LCD_SPACE;
            end
         end
         default:
         begin
            rs_next = 1'b1;   // Idle bus during power-up delay
            rw_next = 1'b1;
         end
      endcase
   end

   always_ff @(posedge CLK)
   begin
      if (!RESETN)
      begin
         half_cnt <= '0;
         LCD_E    <= 1'b0;
         state    <= ST_DELAY;
         step     <= '0;
         LCD_RS   <= 1'b1;
         LCD_RW   <= 1'b1;
         LCD_DATA <= '0;
      end
      else
      begin
         half_cnt <= half_wrap ? '0 : half_cnt + 1'b1;
         if (half_wrap)
            LCD_E <= ~LCD_E;
         if (step_en)
         begin
            LCD_RS   <= rs_next;
            LCD_RW   <= rw_next;
            LCD_DATA <= data_next;
            if (step == last_step)
            begin
               step  <= '0;
               state <= next_state;
            end
            else
               step <= step + 1'b1;
         end
      end
   end

endmodule

// File: src/lcd_watch.sv
`timescale 1ns/1ns

module lcd_watch
   import watch_pkg::*;
(
   input  logic       CLK,
   input  logic       RESETN,
   input  logic       U,
   input  logic       D,
   input  logic [1:0] set_field,
   input  logic       mode,
   output logic       LCD_E,
   output logic       LCD_RS,
   output logic       LCD_RW,
   output logic [7:0] LCD_DATA
);

   set_field_e field_sel;
   disp_mode_e disp_mode;
   logic       sec_up;
   logic       sec_dn;
   logic       min_up;
   logic       min_dn;
   logic       hour_up;
   logic       hour_dn;
   hour_t      hour;
   min_sec_t   minute;
   min_sec_t   second;

   assign field_sel = set_field_e'(set_field);
   assign disp_mode = disp_mode_e'(mode);

   disp_slot_if slot_if ();

   watch_input input_i (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .U         (U),
      .D         (D),
      .set_field (field_sel),
      .sec_up    (sec_up),
      .sec_dn    (sec_dn),
      .min_up    (min_up),
      .min_dn    (min_dn),
      .hour_up   (hour_up),
      .hour_dn   (hour_dn)
   );

   watch_timekeeper timekeeper_i (
      .CLK     (CLK),
      .RESETN  (RESETN),
      .sec_up  (sec_up),
      .sec_dn  (sec_dn),
      .min_up  (min_up),
      .min_dn  (min_dn),
      .hour_up (hour_up),
      .hour_dn (hour_dn),
      .hour    (hour),
      .minute  (minute),
      .second  (second)
   );

   lcd_text_formatter formatter_i (
      .hour   (hour),
      .minute (minute),
      .second (second),
      .mode   (disp_mode),
      .slot   (slot_if.fmt)
   );

   lcd_sequencer sequencer_i (
      .CLK      (CLK),
      .RESETN   (RESETN),
      .slot     (slot_if.seq),
      .LCD_E    (LCD_E),
      .LCD_RS   (LCD_RS),
      .LCD_RW   (LCD_RW),
      .LCD_DATA (LCD_DATA)
   );

endmodule

// File: test/lcd_watch_checker.sv
`timescale 1ns/1ns

`include "watch_config.svh"

module lcd_watch_checker
(
   input  logic         CLK,
   input  logic         RESETN,
   input  logic         LCD_E,
   input  logic         LCD_RS,
   input  logic         LCD_RW,
   input  logic [7:0]   LCD_DATA,
   input  logic         exp_req,      // Held high until exp_done
   input  logic [127:0] exp_name,
   input  logic [127:0] exp_line1,    // '?' matches any character
   input  logic [127:0] exp_line2,
   output logic         exp_done,
   output int           errors,
   output int           init_seen
);

   logic [7:0]   init_cmds [3];
   logic [7:0]   shadow [2][16];
   logic [127:0] act1;
   logic [127:0] act2;
   logic [7:0]   last_cmd;
   logic         e_last;
   logic         cur_line;
   int           cur_col;
   int           rst_cycles;
   logic         started;
   logic         l1_done;
   logic         mismatch;

   initial
   begin
      init_cmds[0] = `LCD_FUNC_SET;
      init_cmds[1] = `LCD_DISP_ON;
      init_cmds[2] = `LCD_ENTRY_MODE;
      exp_done     = 1'b0;
      errors       = 0;
      init_seen    = 0;
      last_cmd     = 8'h00;
      e_last       = 1'b0;
      cur_line     = 1'b0;
      cur_col      = 0;
      rst_cycles   = 0;
      started      = 1'b0;
      l1_done      = 1'b0;
      for (int l = 0; l < 2; l++)
         for (int c = 0; c < 16; c++)
            shadow[l][c] = 8'h00;
   end

   // Packed text to a printable string without null bytes
   function automatic string text_of(input logic [127:0] v);
      string s;
      logic [7:0] b;
      s = "";
      for (int i = 0; i < 16; i++)
      begin
         b = v[8*(15-i) +: 8];
         if (b != 8'h00)
            s = $sformatf("%s%c", s, b);
      end
      return s;
   endfunction

   // Pins must hold their reset values while reset is low
   always @(negedge CLK)
   begin
      if (!RESETN)
      begin
         rst_cycles = rst_cycles + 1;
         if (rst_cycles > 1 && (LCD_E !== 1'b0 || LCD_RS !== 1'b1 ||
                                LCD_RW !== 1'b1 || LCD_DATA !== 8'h00))
         begin
            errors = errors + 1;
            $display("LCD pins are not at their reset values during reset");
         end
      end
   end

   always @(posedge CLK)
   begin
      if (!exp_req)
      begin
         exp_done = 1'b0;
         started  = 1'b0;
         l1_done  = 1'b0;
      end
      // E has just risen with data stable for half a period
      if (RESETN && LCD_E && !e_last && !LCD_RW)
      begin
         if (!LCD_RS)
         begin
            // Repeats of the same command count once
            if (init_seen < 3 && (init_seen == 0 || LCD_DATA !== last_cmd))
            begin
               if (LCD_DATA !== init_cmds[init_seen])
               begin
                  errors = errors + 1;
                  $display("FAIL init_cmd%0d expected %h actual %h",
                           init_seen, init_cmds[init_seen], LCD_DATA);
               end
               init_seen = init_seen + 1;
            end
            else if (init_seen == 3 && LCD_DATA[7])
            begin
               cur_line = LCD_DATA[6];
               cur_col  = int'(LCD_DATA[5:0]);
               if (exp_req && !exp_done && !cur_line && cur_col == 0)
               begin
                  started = 1'b1;   // Fresh pass begins
                  l1_done = 1'b0;
               end
            end
            else if (LCD_DATA !== last_cmd)
            begin
               errors = errors + 1;
               $display("Unexpected LCD command %h after initialization", LCD_DATA);
            end
            last_cmd = LCD_DATA;
         end
         else
         begin
            if (init_seen < 3)
            begin
               errors = errors + 1;
               $display("Character written before the initialization commands finished");
            end
            if (cur_col < 16)
               shadow[cur_line][cur_col] = LCD_DATA;
            if (cur_col == 15)
            begin
               if (!cur_line && started)
                  l1_done = 1'b1;
               if (cur_line && l1_done && exp_req && !exp_done)
               begin
                  mismatch = 1'b0;
                  for (int i = 0; i < 16; i++)
                  begin
                     act1[8*(15-i) +: 8] = shadow[0][i];
                     act2[8*(15-i) +: 8] = shadow[1][i];
                     if (exp_line1[8*(15-i) +: 8] != "?" &&
                         exp_line1[8*(15-i) +: 8] != shadow[0][i])
                        mismatch = 1'b1;
                     if (exp_line2[8*(15-i) +: 8] != "?" &&
                         exp_line2[8*(15-i) +: 8] != shadow[1][i])
                        mismatch = 1'b1;
                  end
                  if (mismatch)
                  begin
                     errors = errors + 1;
                     $display("FAIL %s expected \"%s\" / \"%s\" actual \"%s\" / \"%s\"",
                              text_of(exp_name), text_of(exp_line1), text_of(exp_line2),
                              text_of(act1), text_of(act2));
                  end
                  exp_done = 1'b1;
               end
            end
            cur_col = cur_col + 1;
         end
      end
      e_last = LCD_E;
   end

endmodule

// File: test/lcd_watch_tb.sv
`timescale 1ns/1ns

`include "watch_config.svh"

module lcd_watch_tb;

   logic         CLK;
   logic         RESETN;
   logic         U;
   logic         D;
   logic [1:0]   set_field;
   logic         mode;
   logic         LCD_E;
   logic         LCD_RS;
   logic         LCD_RW;
   logic [7:0]   LCD_DATA;
   logic         exp_req;
   logic [127:0] exp_name;
   logic [127:0] exp_line1;
   logic [127:0] exp_line2;
   logic         exp_done;
   int           check_errors;
   int           init_seen;
   int           stim_errors;
   int           cyc;
   int           fd;
   int           r;
   int           num;
   int           guard;
   logic         abort;
   string        cmd;
   string        arg1;
   string        arg2;
   string        arg3;
   string        skip;

   lcd_watch dut_i (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .U         (U),
      .D         (D),
      .set_field (set_field),
      .mode      (mode),
      .LCD_E     (LCD_E),
      .LCD_RS    (LCD_RS),
      .LCD_RW    (LCD_RW),
      .LCD_DATA  (LCD_DATA)
   );

   lcd_watch_checker checker_i (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .LCD_E     (LCD_E),
      .LCD_RS    (LCD_RS),
      .LCD_RW    (LCD_RW),
      .LCD_DATA  (LCD_DATA),
      .exp_req   (exp_req),
      .exp_name  (exp_name),
      .exp_line1 (exp_line1),
      .exp_line2 (exp_line2),
      .exp_done  (exp_done),
      .errors    (check_errors),
      .init_seen (init_seen)
   );

   initial
   begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // Cycles since reset release, cycle 1 is the first active edge
   always @(posedge CLK)
   begin
      if (!RESETN)
         cyc <= 0;
      else
         cyc <= cyc + 1;
   end

   // Text to packed bytes, '~' stands for a space
   function automatic logic [127:0] pack_text(input string s, input logic tilde);
      logic [127:0] v;
      logic [7:0]   c;
      for (int i = 0; i < 16; i++)
      begin
         c = (i < s.len()) ? s[i] : (tilde ? " " : 8'h00);
         if (tilde && c == "~")
            c = " ";
         v[8*(15-i) +: 8] = c;
      end
      return v;
   endfunction

   task automatic press_button(input string field, input string dir);
      @(negedge CLK);
      case (field)
         "sec":   set_field = 2'd1;
         "min":   set_field = 2'd2;
         "hour":  set_field = 2'd3;
         default:
         begin
            stim_errors++;
            $display("Unknown field %s in press command", field);
         end
      endcase
      if (dir == "U")
         U = 1'b1;
      else
         D = 1'b1;
      repeat (4) @(negedge CLK);
      U = 1'b0;
      D = 1'b0;
      repeat (4) @(negedge CLK);
      set_field = 2'd0;
   endtask

   // Wait until just after the tick that starts the given second
   task automatic wait_second(input int sec);
      int target;
      target = sec * `WATCH_TICK_DIV + 10;
      if (cyc > target)
      begin
         stim_errors++;
         $display("Schedule point at second %0d was already passed", sec);
      end
      guard = 0;
      while (cyc < target && guard < 20 * `WATCH_TICK_DIV)
      begin
         @(negedge CLK);
         guard++;
      end
      if (cyc < target)
      begin
         stim_errors++;
         abort = 1'b1;
         $display("Timed out waiting for second %0d", sec);
      end
   endtask

   task automatic expect_display(input string name, input string l1, input string l2);
      @(negedge CLK);
      exp_name  = pack_text(name, 1'b0);
      exp_line1 = pack_text(l1, 1'b1);
      exp_line2 = pack_text(l2, 1'b1);
      exp_req   = 1'b1;
      guard     = 0;
      while (!exp_done && guard < 4 * `WATCH_TICK_DIV)
      begin
         @(negedge CLK);
         guard++;
      end
      if (!exp_done)
      begin
         stim_errors++;
         abort = 1'b1;
         $display("Timed out waiting for a full display pass for %s", name);
      end
      exp_req = 1'b0;
      @(negedge CLK);
   endtask

   initial
   begin
      RESETN      = 1'b0;
      U           = 1'b0;
      D           = 1'b0;
      set_field   = 2'd0;
      mode        = 1'b0;
      exp_req     = 1'b0;
      exp_name    = '0;
      exp_line1   = '0;
      exp_line2   = '0;
      stim_errors = 0;
      abort       = 1'b0;
      repeat (4) @(negedge CLK);
      RESETN = 1'b1;

      fd = $fopen("test/lcd_watch_stim.txt", "r");
      if (fd == 0)
      begin
         stim_errors++;
         abort = 1'b1;
         $display("Could not open the stimulus file");
      end
      while (!abort && !$feof(fd))
      begin
         r = $fscanf(fd, "%s", cmd);
         if (r != 1)
            break;
         case (cmd)
            "#":      r = $fgets(skip, fd);
            "wait":
            begin
               r = $fscanf(fd, "%d", num);
               repeat (num) @(negedge CLK);
            end
            "at":
            begin
               r = $fscanf(fd, "%d", num);
               wait_second(num);
            end
            "mode":
            begin
               r = $fscanf(fd, "%d", num);
               @(negedge CLK);
               mode = (num == 12);
            end
            "press":
            begin
               r = $fscanf(fd, "%s %s", arg1, arg2);
               press_button(arg1, arg2);
            end
            "expect":
            begin
               r = $fscanf(fd, "%s %s %s", arg1, arg2, arg3);
               expect_display(arg1, arg2, arg3);
            end
            default:
            begin
               stim_errors++;
               $display("Unknown stimulus command %s", cmd);
               r = $fgets(skip, fd);
            end
         endcase
      end
      if (fd != 0)
         $fclose(fd);

      if (init_seen < 3)
      begin
         stim_errors++;
         $display("Only %0d of 3 initialization commands were seen", init_seen);
      end

      $display("Errors: %0d display checks, %0d stimulus or timeout", check_errors,
               stim_errors);
      if (check_errors == 0 && stim_errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: test/lcd_watch_stim.txt
# Commands: wait <cycles>, at <second>, mode <12|24>, press <sec|min|hour> <U|D>
# expect <name> <line1> <line2>, 16 columns each, ~ is a space, ? matches any character
wait 8
expect reset_display ~LCD_WATCH~~~~~~ ~~~00:00~??~~~~~
at 3
press min U
press min U
press min U
press hour D
expect set_min_hour ~LCD_WATCH~~~~~~ ~~~23:03~03~~~~~
at 4
press sec D
press sec D
press sec D
press sec D
expect sec_to_zero ~LCD_WATCH~~~~~~ ~~~23:03~00~~~~~
at 5
press sec D
press sec D
expect sec_down_wrap ~LCD_WATCH~~~~~~ ~~~23:03~59~~~~~
at 6
expect tick_carry ~LCD_WATCH~~~~~~ ~~~23:04~00~~~~~
at 7
press sec D
press sec D
press sec U
expect sec_up_wrap ~LCD_WATCH~~~~~~ ~~~23:04~00~~~~~
at 8
mode 12
expect mode12_pm ~LCD_WATCH~PM~~~ ~~~11:04~01~~~~~
at 9
press hour U
expect mode12_am ~LCD_WATCH~AM~~~ ~~~12:04~02~~~~~
at 10
mode 24
expect tick_before ~LCD_WATCH~~~~~~ ~~~00:04~03~~~~~
at 11
expect tick_after ~LCD_WATCH~~~~~~ ~~~00:04~04~~~~~

// File: vlog.f
+incdir+src
src/watch_pkg.sv
src/lcd_pkg.sv
src/disp_slot_if.sv
src/watch_input.sv
src/watch_timekeeper.sv
src/lcd_text_formatter.sv
src/lcd_sequencer.sv
src/lcd_watch.sv
test/lcd_watch_checker.sv
test/lcd_watch_tb.sv

// File: Bender.yml
package:
  name: lcd_watch

sources:
  - include_dirs:
      - src
    files:
      - src/watch_pkg.sv
      - src/lcd_pkg.sv
      - src/disp_slot_if.sv
      - src/watch_input.sv
      - src/watch_timekeeper.sv
      - src/lcd_text_formatter.sv
      - src/lcd_sequencer.sv
      - src/lcd_watch.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/lcd_watch_checker.sv
      - test/lcd_watch_tb.sv
